// ==== src/cache_dram_pkg.sv ====
// shared widths, DMA packet struct and DRAM channel address union
`default_nettype none

package cache_dram_pkg;

  // data and cache side
  localparam int data_width_c        = 32;
  localparam int cache_addr_width_c  = 16;
  localparam int byte_offset_width_c = 2;

  // word address width inside one cache
  localparam int cache_word_width_c = cache_addr_width_c - byte_offset_width_c;

  // channel address fields
  localparam int bg_width_c   = 1;
  localparam int bank_width_c = 2;
  localparam int row_width_c  = 13;
  localparam int col_width_c  = 6;

  // channel word index, everything above the byte offset
  localparam int dram_word_addr_width_c =
    row_width_c + bg_width_c + bank_width_c + col_width_c;

  // covers the whole channel word space, so any cache id fits
  localparam int dram_words_c = 2 ** dram_word_addr_width_c;

  // block request from a cache
  typedef struct packed {
    logic                          write_not_read;
    logic [cache_addr_width_c-1:0] addr;
  } dma_pkt_s;

  // field order as seen by the controller
  typedef struct packed {
    logic [bg_width_c-1:0]          bg;
    logic [bank_width_c-1:0]        ba;
    logic [row_width_c-1:0]         ro;
    logic [col_width_c-1:0]         co;
    logic [byte_offset_width_c-1:0] byte_offset;
  } dram_ctrl_addr_s;

  // field order as seen by the channel memory
  typedef struct packed {
    logic [row_width_c-1:0]         ro;
    logic [bg_width_c-1:0]          bg;
    logic [bank_width_c-1:0]        ba;
    logic [col_width_c-1:0]         co;
    logic [byte_offset_width_c-1:0] byte_offset;
  } dram_mem_addr_s;

  // one 24-bit address word, two decodings
  typedef union packed {
    dram_ctrl_addr_s ctrl;
    dram_mem_addr_s  mem;
  } dram_ch_addr_u;

endpackage

`default_nettype wire

// ==== src/dma_req_arbiter.sv ====
// round-robin arbiter granting one cache a whole DMA transaction
`timescale 1ns/100ps
`default_nettype none

module dma_req_arbiter #(
  parameter int num_cache_p = 2,
  localparam int idx_width_lp = (num_cache_p > 1) ? $clog2(num_cache_p) : 1
) (
  input  logic                    core_clk,
  input  logic                    rst_i,

  input  logic [num_cache_p-1:0]  req_i,
  input  logic                    xfer_done_i,

  output logic [num_cache_p-1:0]  grant_o,
  output logic                    grant_v_o,
  output logic [idx_width_lp-1:0] grant_idx_o
);

  logic                    grant_v_r;
  // last served cache, also the index of the live grant
  logic [idx_width_lp-1:0] last_r;

  logic                    pick_v;
  logic [idx_width_lp-1:0] pick_idx;

  // search starts one past the last served cache
  always_comb begin : rr_pick
    int cand;
    pick_v   = 1'b0;
    pick_idx = last_r;
    for (int i = 1; i <= num_cache_p; i++) begin
      cand = (int'(last_r) + i) % num_cache_p;
      if (!pick_v && req_i[cand]) begin
        pick_v   = 1'b1;
        pick_idx = idx_width_lp'(cand);
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (rst_i) begin
      grant_v_r <= 1'b0;
      // cache 0 wins the first round
      last_r    <= idx_width_lp'(num_cache_p - 1);
    end else if (grant_v_r) begin
      if (xfer_done_i) begin
        grant_v_r <= 1'b0;
      end
    end else if (pick_v) begin
      grant_v_r <= 1'b1;
      last_r    <= pick_idx;
    end
  end

  always_comb begin
    grant_o         = '0;
    grant_o[last_r] = grant_v_r;
  end

  assign grant_v_o   = grant_v_r;
  assign grant_idx_o = last_r;

endmodule

`default_nettype wire

// ==== src/dram_xfer_ctrl.sv ====
// transaction FSM, channel address mapping and beat counting for the granted cache
`timescale 1ns/100ps
`default_nettype none

module dram_xfer_ctrl
  import cache_dram_pkg::*;
#(
  parameter int num_cache_p           = 2,
  parameter int block_size_in_words_p = 8,
  localparam int idx_width_lp  = (num_cache_p > 1) ? $clog2(num_cache_p) : 1,
  localparam int beat_width_lp =
    (block_size_in_words_p > 1) ? $clog2(block_size_in_words_p) : 1
) (
  input  logic                                     core_clk,
  input  logic                                     rst_i,

  input  logic                                     grant_v_i,
  input  logic [idx_width_lp-1:0]                  grant_idx_i,

  input  dma_pkt_s [num_cache_p-1:0]               dma_pkt_i,
  output logic [num_cache_p-1:0]                   dma_pkt_yumi_o,

  input  logic [num_cache_p-1:0][data_width_c-1:0] dma_data_i,
  input  logic [num_cache_p-1:0]                   dma_data_v_i,
  output logic [num_cache_p-1:0]                   dma_data_yumi_o,

  output logic [num_cache_p-1:0][data_width_c-1:0] dma_data_o,
  output logic [num_cache_p-1:0]                   dma_data_v_o,
  input  logic [num_cache_p-1:0]                   dma_data_ready_i,

  output logic                                     mem_req_v_o,
  output logic                                     mem_write_not_read_o,
  output dram_ch_addr_u                            mem_ch_addr_o,
  output logic [data_width_c-1:0]                  mem_wdata_o,
  input  logic                                     mem_req_yumi_i,

  input  logic [data_width_c-1:0]                  mem_rdata_i,
  input  logic                                     mem_rdata_v_i,

  output logic                                     xfer_done_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_accept,
    st_write,
    st_read_issue,
    st_read_wait
  } state_e;

  state_e                             state_r;
  state_e                             state_n;
  dma_pkt_s                           pkt_r;
  logic [beat_width_lp-1:0]           beat_r;
  logic [data_width_c-1:0]            rdata_r;
  logic                               rdata_v_r;

  logic                               last_beat;
  logic                               wr_beat_done;
  logic                               rd_beat_done;
  logic [dram_word_addr_width_c-1:0]  word_idx;

  assign last_beat    = (beat_r == beat_width_lp'(block_size_in_words_p - 1));
  assign wr_beat_done = (state_r == st_write) & mem_req_yumi_i;
  assign rd_beat_done = (state_r == st_read_wait) & rdata_v_r
                      & dma_data_ready_i[grant_idx_i];
  assign xfer_done_o  = (wr_beat_done | rd_beat_done) & last_beat;

  always_comb begin
    state_n = state_r;
    case (state_r)
      st_idle:       if (grant_v_i) state_n = st_accept;
      st_accept:     state_n = dma_pkt_i[grant_idx_i].write_not_read ? st_write : st_read_issue;
      st_write:      if (wr_beat_done && last_beat) state_n = st_idle;
      st_read_issue: if (mem_req_yumi_i) state_n = st_read_wait;
      st_read_wait:  if (rd_beat_done) state_n = last_beat ? st_idle : st_read_issue;
      default:       state_n = st_idle;
    endcase
  end

  always_ff @(posedge core_clk) begin
    if (rst_i) begin
      state_r   <= st_idle;
      beat_r    <= '0;
      rdata_v_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (state_r == st_accept) begin
        beat_r <= '0;
      end else if (wr_beat_done || rd_beat_done) begin
        beat_r <= beat_r + 1'b1;
      end
      // read word held here until the cache takes it
      if (mem_rdata_v_i) begin
        rdata_v_r <= 1'b1;
      end else if (rd_beat_done) begin
        rdata_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (state_r == st_accept) begin
      pkt_r <= dma_pkt_i[grant_idx_i];
    end
    if (mem_rdata_v_i) begin
      rdata_r <= mem_rdata_i;
    end
  end

  // cache id selects a disjoint slice of the channel
  assign word_idx =
      ((dram_word_addr_width_c)'(grant_idx_i) << cache_word_width_c)
    + (dram_word_addr_width_c)'(pkt_r.addr[cache_addr_width_c-1:byte_offset_width_c])
    + (dram_word_addr_width_c)'(beat_r);

  // column lowest, then bank, bank group, row
  always_comb begin
    mem_ch_addr_o         = '0;
    mem_ch_addr_o.ctrl.co = word_idx[col_width_c-1:0];
    mem_ch_addr_o.ctrl.ba = word_idx[col_width_c +: bank_width_c];
    mem_ch_addr_o.ctrl.bg = word_idx[col_width_c + bank_width_c +: bg_width_c];
    mem_ch_addr_o.ctrl.ro = word_idx[col_width_c + bank_width_c + bg_width_c +: row_width_c];
  end

  assign mem_req_v_o = ((state_r == st_write) & dma_data_v_i[grant_idx_i])
                     | (state_r == st_read_issue);
  assign mem_write_not_read_o = (state_r == st_write);
  assign mem_wdata_o          = dma_data_i[grant_idx_i];

  // only the granted cache sees handshakes and data
  always_comb begin
    for (int c = 0; c < num_cache_p; c++) begin
      if (grant_idx_i == idx_width_lp'(c)) begin
        dma_pkt_yumi_o[c]  = (state_r == st_accept);
        dma_data_yumi_o[c] = wr_beat_done;
        dma_data_v_o[c]    = (state_r == st_read_wait) & rdata_v_r;
        dma_data_o[c]      = rdata_r;
      end else begin
        dma_pkt_yumi_o[c]  = 1'b0;
        dma_data_yumi_o[c] = 1'b0;
        dma_data_v_o[c]    = 1'b0;
        dma_data_o[c]      = '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/dram_channel_mem.sv ====
// word-wide DRAM channel memory with request/yumi and registered read data
`timescale 1ns/100ps
`default_nettype none

module dram_channel_mem
  import cache_dram_pkg::*;
(
  input  logic                    core_clk,
  input  logic                    rst_i,

  input  logic                    req_v_i,
  input  logic                    write_not_read_i,
  input  dram_ch_addr_u           ch_addr_i,
  input  logic [data_width_c-1:0] wdata_i,
  output logic                    req_yumi_o,

  output logic [data_width_c-1:0] rdata_o,
  output logic                    rdata_v_o
);

  logic [data_width_c-1:0]           mem_r [dram_words_c];
  logic [data_width_c-1:0]           rdata_r;
  logic                              rdata_v_r;
  logic [dram_word_addr_width_c-1:0] word_idx;

  // row-major order of the memory side decode
  assign word_idx = {
    ch_addr_i.mem.ro,
    ch_addr_i.mem.bg,
    ch_addr_i.mem.ba,
    ch_addr_i.mem.co
  };

  // never stalls, every request taken on arrival
  assign req_yumi_o = req_v_i;

  always_ff @(posedge core_clk) begin
    if (req_v_i && write_not_read_i) begin
      mem_r[word_idx] <= wdata_i;
    end
    if (req_v_i && !write_not_read_i) begin
      rdata_r <= mem_r[word_idx];
    end
  end

  // valid pulses one cycle after the read yumi
  always_ff @(posedge core_clk) begin
    if (rst_i) begin
      rdata_v_r <= 1'b0;
    end else begin
      rdata_v_r <= req_v_i & ~write_not_read_i;
    end
  end

  assign rdata_o   = rdata_r;
  assign rdata_v_o = rdata_v_r;

endmodule

`default_nettype wire

// ==== src/cache_to_dram.sv ====
// top level joining the cache DMA ports to one DRAM channel
`timescale 1ns/100ps
`default_nettype none

module cache_to_dram
  import cache_dram_pkg::*;
#(
  parameter int num_cache_p           = 2,
  parameter int block_size_in_words_p = 8,
  localparam int idx_width_lp = (num_cache_p > 1) ? $clog2(num_cache_p) : 1
) (
  input  logic                                     core_clk,
  input  logic                                     rst_i,

  input  dma_pkt_s [num_cache_p-1:0]               dma_pkt_i,
  input  logic [num_cache_p-1:0]                   dma_pkt_v_i,
  output logic [num_cache_p-1:0]                   dma_pkt_yumi_o,

  input  logic [num_cache_p-1:0][data_width_c-1:0] dma_data_i,
  input  logic [num_cache_p-1:0]                   dma_data_v_i,
  output logic [num_cache_p-1:0]                   dma_data_yumi_o,

  output logic [num_cache_p-1:0][data_width_c-1:0] dma_data_o,
  output logic [num_cache_p-1:0]                   dma_data_v_o,
  input  logic [num_cache_p-1:0]                   dma_data_ready_i
);

  // arbiter to controller
  logic                    grant_v;
  logic [idx_width_lp-1:0] grant_idx;
  logic                    xfer_done;

  // controller to channel memory
  logic                    mem_req_v;
  logic                    mem_write_not_read;
  dram_ch_addr_u           mem_ch_addr;
  logic [data_width_c-1:0] mem_wdata;
  logic                    mem_req_yumi;
  logic [data_width_c-1:0] mem_rdata;
  logic                    mem_rdata_v;

  dma_req_arbiter #(
    .num_cache_p(num_cache_p)
  ) arb0 (
    .core_clk(core_clk)
    ,.rst_i(rst_i)
    ,.req_i(dma_pkt_v_i)
    ,.xfer_done_i(xfer_done)
    ,.grant_o()
    ,.grant_v_o(grant_v)
    ,.grant_idx_o(grant_idx)
  );

  dram_xfer_ctrl #(
    .num_cache_p(num_cache_p)
    ,.block_size_in_words_p(block_size_in_words_p)
  ) ctrl0 (
    .core_clk(core_clk)
    ,.rst_i(rst_i)
    ,.grant_v_i(grant_v)
    ,.grant_idx_i(grant_idx)
    ,.dma_pkt_i(dma_pkt_i)
    ,.dma_pkt_yumi_o(dma_pkt_yumi_o)
    ,.dma_data_i(dma_data_i)
    ,.dma_data_v_i(dma_data_v_i)
    ,.dma_data_yumi_o(dma_data_yumi_o)
    ,.dma_data_o(dma_data_o)
    ,.dma_data_v_o(dma_data_v_o)
    ,.dma_data_ready_i(dma_data_ready_i)
    ,.mem_req_v_o(mem_req_v)
    ,.mem_write_not_read_o(mem_write_not_read)
    ,.mem_ch_addr_o(mem_ch_addr)
    ,.mem_wdata_o(mem_wdata)
    ,.mem_req_yumi_i(mem_req_yumi)
    ,.mem_rdata_i(mem_rdata)
    ,.mem_rdata_v_i(mem_rdata_v)
    ,.xfer_done_o(xfer_done)
  );

  dram_channel_mem mem0 (
    .core_clk(core_clk)
    ,.rst_i(rst_i)
    ,.req_v_i(mem_req_v)
    ,.write_not_read_i(mem_write_not_read)
    ,.ch_addr_i(mem_ch_addr)
    ,.wdata_i(mem_wdata)
    ,.req_yumi_o(mem_req_yumi)
    ,.rdata_o(mem_rdata)
    ,.rdata_v_o(mem_rdata_v)
  );

endmodule

`default_nettype wire

// ==== bench/cache_to_dram_chk.sv ====
// bound checker with concurrent assertions on the cache DMA handshakes
`timescale 1ns/100ps
`default_nettype none

module cache_to_dram_chk
  import cache_dram_pkg::*;
#(
  parameter int num_cache_p = 2
) (
  input logic                                     core_clk,
  input logic                                     rst_i,
  input logic [num_cache_p-1:0]                   pkt_v_i,
  input logic [num_cache_p-1:0]                   pkt_yumi_i,
  input logic [num_cache_p-1:0]                   data_v_i,
  input logic [num_cache_p-1:0]                   data_yumi_i,
  input logic [num_cache_p-1:0][data_width_c-1:0] rd_data_i,
  input logic [num_cache_p-1:0]                   rd_v_i,
  input logic [num_cache_p-1:0]                   rd_ready_i
);

  // one transaction at a time, so at most one yumi of either kind
  yumi_onehot_a: assert property (@(posedge core_clk) disable iff (rst_i)
    $onehot0({pkt_yumi_i, data_yumi_i}))
    else $error("more than one yumi in one cycle");

  for (genvar c = 0; c < num_cache_p; c++) begin : g_cache
    pkt_yumi_v_a: assert property (@(posedge core_clk) disable iff (rst_i)
      pkt_yumi_i[c] |-> pkt_v_i[c])
      else $error("packet yumi without valid on cache %0d", c);

    data_yumi_v_a: assert property (@(posedge core_clk) disable iff (rst_i)
      data_yumi_i[c] |-> data_v_i[c])
      else $error("data yumi without valid on cache %0d", c);

    // held word stays put until the cache takes it
    rd_hold_a: assert property (@(posedge core_clk) disable iff (rst_i)
      (rd_v_i[c] && !rd_ready_i[c]) |=> (rd_v_i[c] && $stable(rd_data_i[c])))
      else $error("read data moved under back-pressure on cache %0d", c);
  end

endmodule

`default_nettype wire

// ==== bench/cache_to_dram_tb.sv ====
// testbench for cache_to_dram with stimulus table, cache-side drivers, reference model and checks
`timescale 1ns/100ps
`default_nettype none

module cache_to_dram_tb
  import cache_dram_pkg::*;
();

  localparam int num_cache_c   = 2;
  localparam int block_words_c = 8;
  localparam int timeout_c     = 200;
  localparam int drive_dly_c   = 2;

  typedef struct packed {
    logic [1:0]  mask;
    logic        wr;
    logic [15:0] addr;
    logic [31:0] seed;
    logic        throttle;
    logic        exp_first;
  } stim_s;

  // mask selects the caches
  // exp_first is the cache whose packet goes first
  localparam int num_stim_c = 14;
  localparam stim_s stim_c [num_stim_c] = '{
    '{2'b01, 1'b1, 16'h0040, 32'h1000_0000, 1'b0, 1'b0},
    '{2'b01, 1'b0, 16'h0040, 32'h0000_0000, 1'b0, 1'b0},
    '{2'b10, 1'b1, 16'h0040, 32'h2000_0000, 1'b0, 1'b1},
    '{2'b01, 1'b0, 16'h0040, 32'h0000_0000, 1'b0, 1'b0},
    '{2'b10, 1'b0, 16'h0040, 32'h0000_0000, 1'b0, 1'b1},
    '{2'b11, 1'b1, 16'h0100, 32'h3000_0000, 1'b0, 1'b0},
    '{2'b11, 1'b0, 16'h0100, 32'h0000_0000, 1'b0, 1'b0},
    '{2'b01, 1'b1, 16'h0300, 32'h4000_0000, 1'b0, 1'b0},
    '{2'b11, 1'b1, 16'h0400, 32'h5000_0000, 1'b0, 1'b1},
    '{2'b11, 1'b0, 16'h0400, 32'h0000_0000, 1'b0, 1'b1},
    '{2'b10, 1'b1, 16'hffe0, 32'h6000_0000, 1'b0, 1'b1},
    '{2'b01, 1'b0, 16'h0040, 32'h0000_0000, 1'b1, 1'b0},
    '{2'b10, 1'b0, 16'hffe0, 32'h0000_0000, 1'b1, 1'b1},
    '{2'b11, 1'b0, 16'h0400, 32'h0000_0000, 1'b1, 1'b0}
  };

  logic                                     core_clk;
  logic                                     rst_i;
  dma_pkt_s [num_cache_c-1:0]               pkt;
  logic [num_cache_c-1:0]                   pkt_v;
  logic [num_cache_c-1:0]                   pkt_yumi;
  logic [num_cache_c-1:0][data_width_c-1:0] wdata;
  logic [num_cache_c-1:0]                   wdata_v;
  logic [num_cache_c-1:0]                   wdata_yumi;
  logic [num_cache_c-1:0][data_width_c-1:0] rdata;
  logic [num_cache_c-1:0]                   rdata_v;
  logic [num_cache_c-1:0]                   rdata_ready;

  // expected contents, per cache and cache word address
  logic [data_width_c-1:0] ref_mem [num_cache_c][2**cache_word_width_c];
  int                      yumi_order [$];
  integer                  seed;

  always #20 core_clk = ~core_clk;

  cache_to_dram #(
    .num_cache_p(num_cache_c),
    .block_size_in_words_p(block_words_c)
  ) dut0 (
    .core_clk(core_clk),
    .rst_i(rst_i),
    .dma_pkt_i(pkt),
    .dma_pkt_v_i(pkt_v),
    .dma_pkt_yumi_o(pkt_yumi),
    .dma_data_i(wdata),
    .dma_data_v_i(wdata_v),
    .dma_data_yumi_o(wdata_yumi),
    .dma_data_o(rdata),
    .dma_data_v_o(rdata_v),
    .dma_data_ready_i(rdata_ready)
  );

  bind cache_to_dram cache_to_dram_chk #(.num_cache_p(num_cache_p)) chk0 (
    .core_clk(core_clk),
    .rst_i(rst_i),
    .pkt_v_i(dma_pkt_v_i),
    .pkt_yumi_i(dma_pkt_yumi_o),
    .data_v_i(dma_data_v_i),
    .data_yumi_i(dma_data_yumi_o),
    .rd_data_i(dma_data_o),
    .rd_v_i(dma_data_v_o),
    .rd_ready_i(dma_data_ready_i)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s, got %h expected %h",
                          $time, what, got, exp));
    end
  endtask

  task automatic to_drive_point();
    @(posedge core_clk);
    #(drive_dly_c);
  endtask

  task automatic to_sample_point();
    @(negedge core_clk);
  endtask

  // one block transfer on cache c, entered and left at a drive point
  task automatic run_block(input int c, input logic wr, input logic [15:0] addr,
                           input logic [31:0] dseed, input logic throttle);
    logic [13:0] w;
    logic [31:0] rnd;
    int          n;
    int          b;
    w = addr[15:2];
    pkt[c].write_not_read = wr;
    pkt[c].addr = addr;
    pkt_v[c] = 1'b1;
    n = 0;
    to_sample_point();
    while (!pkt_yumi[c]) begin
      n++;
      if (n > timeout_c) begin
        abort_run($sformatf("timeout at %0t: no packet yumi for cache %0d", $time, c));
      end
      to_drive_point();
      to_sample_point();
    end
    yumi_order.push_back(c);
    to_drive_point();
    pkt_v[c] = 1'b0;
    if (wr) begin
      for (b = 0; b < block_words_c; b++) begin
        wdata[c] = dseed + 32'h0100_0193 * 32'(b);
        wdata_v[c] = 1'b1;
        ref_mem[c][w + 14'(b)] = wdata[c];
        n = 0;
        to_sample_point();
        while (!wdata_yumi[c]) begin
          n++;
          if (n > timeout_c) begin
            abort_run($sformatf("timeout at %0t: write word %0d of cache %0d not taken",
                                $time, b, c));
          end
          to_drive_point();
          to_sample_point();
        end
        to_drive_point();
      end
      wdata_v[c] = 1'b0;
    end else begin
      b = 0;
      n = 0;
      while (b < block_words_c) begin
        rnd = $random(seed);
        rdata_ready[c] = throttle ? rnd[0] : 1'b1;
        to_sample_point();
        if (rdata_v[c] && rdata_ready[c]) begin
          check_equal(rdata[c], ref_mem[c][w + 14'(b)],
                      $sformatf("cache %0d read word %0d", c, b));
          b++;
          n = 0;
        end else begin
          n++;
          if (n > timeout_c) begin
            abort_run($sformatf("timeout at %0t: read word %0d of cache %0d never came",
                                $time, b, c));
          end
        end
        to_drive_point();
      end
      rdata_ready[c] = 1'b0;
    end
  endtask

  initial begin
    stim_s e;
    core_clk    = 1'b0;
    rst_i       = 1'b1;
    pkt         = '0;
    pkt_v       = '0;
    wdata       = '0;
    wdata_v     = '0;
    rdata_ready = '0;
    seed        = 32'hfd41816c;
    // reset seen by 16 rising edges, outputs quiet throughout
    repeat (15) begin
      to_drive_point();
      to_sample_point();
      check_equal(32'({pkt_yumi, wdata_yumi, rdata_v}), 32'h0, "handshakes in reset");
    end
    to_drive_point();
    rst_i = 1'b0;
    to_sample_point();
    check_equal(32'({pkt_yumi, wdata_yumi, rdata_v}), 32'h0, "handshakes after reset");
    to_drive_point();
    for (int i = 0; i < num_stim_c; i++) begin
      e = stim_c[i];
      yumi_order.delete();
      fork
        if (e.mask[0]) run_block(0, e.wr, e.addr, e.seed, e.throttle);
        if (e.mask[1]) run_block(1, e.wr, e.addr, ~e.seed, e.throttle);
      join
      // order only matters when both caches compete
      if (e.mask == 2'b11) begin
        check_equal(32'(yumi_order[0]), 32'(e.exp_first),
                    $sformatf("entry %0d first packet yumi", i));
        check_equal(32'(yumi_order[1]), 32'(!e.exp_first),
                    $sformatf("entry %0d second packet yumi", i));
      end
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
src/cache_dram_pkg.sv
src/dma_req_arbiter.sv
src/dram_xfer_ctrl.sv
src/dram_channel_mem.sv
src/cache_to_dram.sv
bench/cache_to_dram_chk.sv
bench/cache_to_dram_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache to DRAM testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module cache_to_dram_tb \
	  -f files.f -o Vcache_to_dram_tb

run: compile
	obj_dir/Vcache_to_dram_tb

clean:
	rm -rf obj_dir
